// ==== hdl/readPkg.sv ====
`default_nettype none

package readPkg;

	// ----------------------------------------------------------
	// Channel and block geometry
	// ----------------------------------------------------------

	localparam int CHANNELS = 5;
	localparam int BLOCK_WORDS = 18;
	localparam int CH_WIDTH = 3;

	// ----------------------------------------------------------
	// Slot timing, in clock cycles
	// ----------------------------------------------------------

	localparam int SLOT_LEN = 64;
	localparam int RD_START = 40;
	localparam int RD_LEN = 4;
	localparam int SLOT_WIDTH = $clog2(SLOT_LEN);

	// ----------------------------------------------------------
	// Word store
	// ----------------------------------------------------------

	localparam int DATA_WIDTH = 16;
	localparam int ADR_WIDTH = 5;
	localparam int ROM_DEPTH = CHANNELS * BLOCK_WORDS;
	localparam int ROM_ADR_WIDTH = $clog2(ROM_DEPTH);

	// One bit per channel.
	typedef logic [CHANNELS-1:0] chanMask_t;

	typedef struct packed {
		logic [CH_WIDTH-1:0] chan;
		logic [ADR_WIDTH-1:0] adr;
		logic [DATA_WIDTH-1:0] data;
	} wordOut_t;

	// Each channel owns a bank of BLOCK_WORDS words.
	function automatic logic [ROM_ADR_WIDTH-1:0] romIndex(
		input logic [CH_WIDTH-1:0] chan,
		input logic [ADR_WIDTH-1:0] adr
	);
		return ROM_ADR_WIDTH'(chan * BLOCK_WORDS + adr);
	endfunction

endpackage

`default_nettype wire

// ==== hdl/strobeSync.sv ====
`timescale 1ns/1ns
`default_nettype none

module strobeSync
	import readPkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire chanMask_t strobe,
	output chanMask_t syncStrobe
);

	chanMask_t meta;

	// Strobes come from outside the clock domain.
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			meta <= '0;
			syncStrobe <= '0;
		end else begin
			meta <= strobe;
			syncStrobe <= meta;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/turnArbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module turnArbiter
	import readPkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire chanMask_t pending,
	input wire chanMask_t done,
	output chanMask_t grant,
	output logic busy
);

	logic [CH_WIDTH-1:0] lastIdx;
	logic [CH_WIDTH-1:0] pickIdx;
	logic pickValid;
	logic turnFree;

	// ----------------------------------------------------------
	// Cyclic search from the channel after the last one served
	// ----------------------------------------------------------

	// Walk the offsets from far to near, so the nearest pending channel
	// is the one left in pickIdx.
	always_comb begin : pickNext
		int cand;
		pickIdx = lastIdx;
		pickValid = 1'b0;
		for (int step = CHANNELS; step >= 1; step--) begin
			cand = int'(lastIdx) + step;
			if (cand >= CHANNELS) begin
				cand = cand - CHANNELS;
			end
			if (pending[cand]) begin
				pickIdx = CH_WIDTH'(cand);
				pickValid = 1'b1;
			end
		end
	end

	// The turn is free when nobody holds it, or its holder just finished.
	assign turnFree = (grant == '0) || ((done & grant) != '0);

	// ----------------------------------------------------------
	// Grant register
	// ----------------------------------------------------------

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			grant <= '0;
			// Start so that channel 0 is searched first.
			lastIdx <= CH_WIDTH'(CHANNELS - 1);
		end else if (turnFree) begin
			if (pickValid) begin
				grant <= chanMask_t'(1) << pickIdx;
				lastIdx <= pickIdx;
			end else begin
				grant <= '0;
			end
		end
	end

	// Back-to-back grants keep this high between blocks.
	assign busy = |grant;

endmodule

`default_nettype wire

// ==== hdl/readSequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module readSequencer
	import readPkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic syncStrobe,
	input wire logic grant,
	output logic pending,
	output logic done,
	output logic rd,
	output logic [ADR_WIDTH-1:0] rdAdr
);

	typedef enum logic [2:0] {
		Idle,
		WaitTurn,
		Slot,
		Advance,
		Release
	} seqState_t;

	seqState_t state;
	logic [SLOT_WIDTH-1:0] slotCnt;
	logic lastWord;
	logic rdSet;
	logic rdClear;
	logic slotEnd;

	// ----------------------------------------------------------
	// Slot decode
	// ----------------------------------------------------------

	// RD is registered, so it is set one count early to be high
	// while the slot counter reads RD_START through RD_START + RD_LEN - 1.
	assign rdSet = (slotCnt == SLOT_WIDTH'(RD_START - 1));
	assign rdClear = (slotCnt == SLOT_WIDTH'(RD_START + RD_LEN - 1));
	assign slotEnd = (slotCnt == SLOT_WIDTH'(SLOT_LEN - 1));
	assign lastWord = (rdAdr == ADR_WIDTH'(BLOCK_WORDS - 1));

	assign pending = (state == WaitTurn);

	// Single cycle, in the address-advance cycle of the last word.
	assign done = (state == Advance) && lastWord;

	// ----------------------------------------------------------
	// Block FSM
	// ----------------------------------------------------------

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= Idle;
			slotCnt <= '0;
			rd <= 1'b0;
			rdAdr <= '0;
		end else begin
			case (state)
				Idle: begin
					if (syncStrobe) begin
						state <= WaitTurn;
					end
				end
				WaitTurn: begin
					if (grant) begin
						slotCnt <= '0;
						state <= Slot;
					end
				end
				Slot: begin
					slotCnt <= slotCnt + 1'b1;
					if (rdSet) begin
						rd <= 1'b1;
					end else if (rdClear) begin
						rd <= 1'b0;
					end
					if (slotEnd) begin
						slotCnt <= '0;
						state <= Advance;
					end
				end
				Advance: begin
					if (lastWord) begin
						rdAdr <= '0;
						state <= Release;
					end else begin
						rdAdr <= rdAdr + 1'b1;
						state <= Slot;
					end
				end
				Release: begin
					// A held strobe must drop before a new request.
					if (!syncStrobe) begin
						state <= Idle;
					end
				end
				default: begin
					state <= Idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/sampleRom.sv ====
`timescale 1ns/1ns
`default_nettype none

module sampleRom
	import readPkg::*;
(
	input wire logic clk,
	input wire logic rdEn,
	input wire logic [ROM_ADR_WIDTH-1:0] adr,
	output logic [DATA_WIDTH-1:0] data
);

	logic [DATA_WIDTH-1:0] mem [ROM_DEPTH];

	// Bank 0 first, BLOCK_WORDS lines per bank.
	initial begin
		$readmemh("sampleRom.mem", mem);
	end

	// Output holds between reads.
	always_ff @(posedge clk) begin
		if (rdEn) begin
			data <= mem[adr];
		end
	end

endmodule

`default_nettype wire

// ==== hdl/multiReader.sv ====
`timescale 1ns/1ns
`default_nettype none

module multiReader
	import readPkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire chanMask_t strobe,
	output chanMask_t rd,
	output logic [ADR_WIDTH-1:0] rdAdr [CHANNELS],
	output logic busy,
	output wordOut_t word,
	output logic wordValid
);

	chanMask_t syncStrobe;
	chanMask_t pending;
	chanMask_t done;
	chanMask_t grant;

	logic [CH_WIDTH-1:0] grantIdx;
	logic [ADR_WIDTH-1:0] selAdr;
	logic [ROM_ADR_WIDTH-1:0] romAdr;
	logic [DATA_WIDTH-1:0] romData;
	logic rdAny;
	logic rdAnyQ;
	logic [CH_WIDTH-1:0] chanQ;
	logic [ADR_WIDTH-1:0] adrQ;

	// ----------------------------------------------------------
	// Strobe input and turn logic
	// ----------------------------------------------------------

	strobeSync uSync (
		.clk(clk),
		.rst(rst),
		.strobe(strobe),
		.syncStrobe(syncStrobe)
	);

	turnArbiter uArbiter (
		.clk(clk),
		.rst(rst),
		.pending(pending),
		.done(done),
		.grant(grant),
		.busy(busy)
	);

	for (genvar ch = 0; ch < CHANNELS; ch++) begin : genSeq
		readSequencer uSeq (
			.clk(clk),
			.rst(rst),
			.syncStrobe(syncStrobe[ch]),
			.grant(grant[ch]),
			.pending(pending[ch]),
			.done(done[ch]),
			.rd(rd[ch]),
			.rdAdr(rdAdr[ch])
		);
	end

	// ----------------------------------------------------------
	// ROM read path
	// ----------------------------------------------------------

	// Grant is one-hot.
	always_comb begin
		grantIdx = '0;
		for (int i = 0; i < CHANNELS; i++) begin
			if (grant[i]) begin
				grantIdx = CH_WIDTH'(i);
			end
		end
	end

	// Only the granted channel can raise rd.
	assign selAdr = rdAdr[grantIdx];
	assign romAdr = romIndex(grantIdx, selAdr);
	assign rdAny = |rd;

	sampleRom uRom (
		.clk(clk),
		.rdEn(rdAny),
		.adr(romAdr),
		.data(romData)
	);

	// Tag registers load with the ROM, so they line up with romData.
	always_ff @(posedge clk) begin
		if (rdAny) begin
			chanQ <= grantIdx;
			adrQ <= selAdr;
		end
	end

	// One word per RD pulse, flagged from its rising edge.
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rdAnyQ <= 1'b0;
			wordValid <= 1'b0;
		end else begin
			rdAnyQ <= rdAny;
			wordValid <= rdAny && !rdAnyQ;
		end
	end

	always_comb begin
		word.chan = chanQ;
		word.adr = adrQ;
		word.data = romData;
	end

endmodule

`default_nettype wire

// ==== sim/clockGen.sv ====
`timescale 1ns/1ns
`default_nettype none

module clockGen (
	output logic clk,
	output logic rst
);

	localparam int HALF_PERIOD = 50;
	localparam int RESET_CYCLES = 2;

	initial begin
		clk = 1'b0;
		forever begin
			#HALF_PERIOD clk = ~clk;
		end
	end

	// Released on a falling edge, clear of the active edge.
	initial begin
		rst = 1'b0;
		repeat (RESET_CYCLES) begin
			@(negedge clk);
		end
		rst = 1'b1;
	end

endmodule

`default_nettype wire

// ==== sim/multiReaderTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module multiReaderTb
	import readPkg::*;
();

	localparam int SLOT_CYCLES = SLOT_LEN + 1;
	localparam int BLOCK_CYCLES = BLOCK_WORDS * SLOT_CYCLES;
	localparam int RANDOM_ROUNDS = 2;
	// About five full rounds of all channels, plus margin.
	localparam int TIMEOUT_CYCLES = 5 * CHANNELS * BLOCK_CYCLES + 750;

	logic clk;
	logic rst;
	chanMask_t strobe;
	chanMask_t rd;
	logic [ADR_WIDTH-1:0] rdAdr [CHANNELS];
	logic busy;
	wordOut_t word;
	logic wordValid;

	logic [DATA_WIDTH-1:0] refMem [ROM_DEPTH];
	int expBlocks[$];
	int wordCount = 0;
	// Channel 0 is searched first after reset.
	int lastServed = CHANNELS - 1;
	logic [31:0] lfsrState = 32'h1cc2_4f05;
	int cycleCount = 0;
	int negCycle = 0;
	int lastRise = 0;
	int rdHigh = 0;
	chanMask_t rdPrev = '0;

	clockGen uClock (
		.clk(clk),
		.rst(rst)
	);

	multiReader UUT (
		.clk(clk),
		.rst(rst),
		.strobe(strobe),
		.rd(rd),
		.rdAdr(rdAdr),
		.busy(busy),
		.word(word),
		.wordValid(wordValid)
	);

	// ----------------------------------------------------------
	// Helpers
	// ----------------------------------------------------------

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("** Error at %0t ns: %s is %0h, expected %0h", $time, name, actual,
				expected);
			$display("Errors found");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	// Expected word of a channel's bank in the ROM image copy.
	function automatic logic [DATA_WIDTH-1:0] expectedWord(input int chan, input int adr);
		return refMem[chan * BLOCK_WORDS + adr];
	endfunction

	// Taps 32, 22, 2, 1.
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic drawMask(output chanMask_t mask);
		for (int i = 0; i < CHANNELS; i++) begin
			lfsrState = lfsrNext(lfsrState);
			mask[i] = lfsrState[0];
		end
	endtask

	// Predicts the turn order by a cyclic search after the last channel served.
	task automatic queueTurns(input chanMask_t mask);
		int start;
		int ch;
		start = lastServed;
		for (int step = 1; step <= CHANNELS; step++) begin
			ch = (start + step) % CHANNELS;
			if (mask[ch]) begin
				expBlocks.push_back(ch);
				lastServed = ch;
			end
		end
	endtask

	task automatic waitIdle();
		@(negedge clk);
		while (expBlocks.size() != 0 || busy) begin
			@(negedge clk);
		end
	endtask

	// Busy must hold from the first grant until the last queued block is read.
	task automatic runChain();
		while (!busy) begin
			@(negedge clk);
		end
		while (expBlocks.size() != 0) begin
			checkValue("busy", 32'(busy), 32'd1);
			@(negedge clk);
		end
		waitIdle();
	endtask

	task automatic dropStrobes();
		strobe = '0;
		repeat (4) begin
			@(negedge clk);
		end
	endtask

	// ----------------------------------------------------------
	// Monitors
	// ----------------------------------------------------------

	always @(negedge clk) begin : compareWords
		int ch;
		if (rst && wordValid) begin
			checkValue("word expected", 32'(expBlocks.size() != 0), 32'd1);
			ch = expBlocks[0];
			checkValue("word.chan", 32'(word.chan), 32'(ch));
			checkValue("word.adr", 32'(word.adr), 32'(wordCount));
			checkValue("word.data", 32'(word.data), 32'(expectedWord(ch, wordCount)));
			wordCount++;
			if (wordCount == BLOCK_WORDS) begin
				wordCount = 0;
				void'(expBlocks.pop_front());
			end
		end
	end

	always @(negedge clk) begin : watchRd
		int ch;
		if (rst) begin
			negCycle++;
			checkValue("rd one-hot", 32'($countones(rd) <= 1), 32'd1);
			if (rd != '0 && rdPrev == '0) begin
				ch = 0;
				for (int i = 0; i < CHANNELS; i++) begin
					if (rd[i]) begin
						ch = i;
					end
				end
				checkValue("rd expected", 32'(expBlocks.size() != 0), 32'd1);
				checkValue("rd channel", 32'(ch), 32'(expBlocks[0]));
				checkValue($sformatf("rdAdr[%0d]", ch), 32'(rdAdr[ch]), 32'(wordCount));
				// Word 0 opens a block, so there is no earlier rise to measure.
				if (wordCount != 0) begin
					checkValue("rd rise spacing", 32'(negCycle - lastRise), 32'(SLOT_CYCLES));
				end
				lastRise = negCycle;
				rdHigh = 0;
			end
			if (rd != '0) begin
				rdHigh++;
			end else if (rdPrev != '0) begin
				checkValue("rd pulse length", 32'(rdHigh), 32'(RD_LEN));
			end
			rdPrev = rd;
		end
	end

	always @(posedge clk) begin : watchdog
		cycleCount++;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Errors found");
			$fatal(1, "Timeout");
		end
	end

	// ----------------------------------------------------------
	// Stimulus
	// ----------------------------------------------------------

	initial begin : stimulus
		chanMask_t mask;
		strobe = '0;
		$readmemh("sampleRom.mem", refMem);
		@(posedge rst);
		@(negedge clk);

		checkValue("rd", 32'(rd), 32'd0);
		checkValue("busy", 32'(busy), 32'd0);
		checkValue("wordValid", 32'(wordValid), 32'd0);
		for (int i = 0; i < CHANNELS; i++) begin
			checkValue($sformatf("rdAdr[%0d]", i), 32'(rdAdr[i]), 32'd0);
		end

		// A single channel whose strobe drops in the middle of its block.
		strobe[2] = 1'b1;
		queueTurns(chanMask_t'(1) << 2);
		while (!busy) begin
			@(negedge clk);
		end
		repeat (BLOCK_CYCLES / 3) begin
			@(negedge clk);
		end
		strobe[2] = 1'b0;
		waitIdle();

		// A held strobe gives one block only until it is released.
		strobe[3] = 1'b1;
		queueTurns(chanMask_t'(1) << 3);
		waitIdle();
		repeat (3 * SLOT_CYCLES) begin
			@(negedge clk);
			checkValue("busy with held strobe", 32'(busy), 32'd0);
		end
		dropStrobes();
		strobe[3] = 1'b1;
		queueTurns(chanMask_t'(1) << 3);
		waitIdle();
		dropStrobes();

		// All channels at once and then random masks.
		strobe = '1;
		queueTurns('1);
		runChain();
		dropStrobes();
		for (int r = 0; r < RANDOM_ROUNDS; r++) begin
			drawMask(mask);
			while (mask == '0) begin
				drawMask(mask);
			end
			strobe = mask;
			queueTurns(mask);
			runChain();
			dropStrobes();
		end

		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sampleRom.mem ====
// One 16-bit hex word per line; 18 lines per bank, bank 0 first (index = bank * 18 + word)
00FF
01FE
02FD
03FC
04FB
05FA
06F9
07F8
08F7
09F6
0AF5
0BF4
0CF3
0DF2
0EF1
0FF0
10EF
11EE
12ED
13EC
14EB
15EA
16E9
17E8
18E7
19E6
1AE5
1BE4
1CE3
1DE2
1EE1
1FE0
20DF
21DE
22DD
23DC
24DB
25DA
26D9
27D8
28D7
29D6
2AD5
2BD4
2CD3
2DD2
2ED1
2FD0
30CF
31CE
32CD
33CC
34CB
35CA
36C9
37C8
38C7
39C6
3AC5
3BC4
3CC3
3DC2
3EC1
3FC0
40BF
41BE
42BD
43BC
44BB
45BA
46B9
47B8
48B7
49B6
4AB5
4BB4
4CB3
4DB2
4EB1
4FB0
50AF
51AE
52AD
53AC
54AB
55AA
56A9
57A8
58A7
59A6

// ==== project.f ====
hdl/readPkg.sv
hdl/strobeSync.sv
hdl/turnArbiter.sv
hdl/readSequencer.sv
hdl/sampleRom.sv
hdl/multiReader.sv
sim/clockGen.sv
sim/multiReaderTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= multiReaderTb
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?=

FAIL_MSG := Errors found
PASS_MSG := No errors
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST) $(wildcard hdl/*.sv) $(wildcard sim/*.sv)
	$(VERILATOR) --binary --timing --timescale 1ns/1ns -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR) $(VFLAGS)

test: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Test failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Test ended without a result"; exit 1; fi
	@echo "Test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
